/* logic/hd_pkg.sv */
// huffman codebook shared definitions
// widths for symbols, code paths and counts, plus the decoder and
// serializer state encodings

package hd_pkg;

  localparam int SYM_COUNT = 256; // one codebook entry per byte value

  typedef logic [7:0]   sym_t;       // a symbol value
  typedef logic [127:0] code_path_t; // sentinel 1 then moves, last move at bit 0
  typedef logic [31:0]  tot_count_t; // total symbols in the file
  typedef logic [6:0]   path_len_t;  // code length, 1 to 127

  typedef enum logic [2:0] {
    HD_IDLE,       // waiting for hd_enable
    HD_FETCH,      // byte request and its two wait cycles
    HD_READ_NODE,  // one tree bit, 0 internal node, 1 leaf
    HD_READ_SYM,   // eight symbol bits of a leaf
    HD_WRITE_PATH, // one write into the codebook
    HD_BACKTRACK,  // climb to the next unvisited right branch
    HD_READ_TOTAL, // 32 count bits after the tree
    HD_DONE        // header parsed, holds until reset
  } hd_state_t;

  typedef enum logic [1:0] {
    SER_IDLE,   // waiting for an accepted sym_req
    SER_LOOKUP, // codebook read in flight
    SER_SHIFT   // code bits going out, first cycle may flag a miss
  } ser_state_t;

endpackage

/* logic/header_decoder.sv */
// huffman header decoder
// walks the preorder tree bitstream coming from the spi byte source,
// writes one code path per leaf into the codebook and then captures the
// 32-bit total symbol count that follows the tree

`timescale 1ns/1ps

module header_decoder (
  input  logic               clk,
  input  logic               rst,
  input  logic               hd_enable,
  input  hd_pkg::sym_t       spi_byte,
  output logic               byte_req,
  output logic               cb_wr_en,
  output hd_pkg::sym_t       cb_wr_sym,
  output hd_pkg::code_path_t cb_wr_path,
  output hd_pkg::tot_count_t tot_chars,
  output logic               hd_finished
);
  import hd_pkg::*;

  localparam code_path_t ROOT_PATH = code_path_t'(1); // sentinel alone, no moves yet

  hd_state_t  state, next_state;
  hd_state_t  ret_state, next_ret_state; // where to go once a fetched byte is in
  code_path_t path, next_path;           // path of the node being visited
  logic [3:0] bit_ptr, next_bit_ptr;     // next bit of spi_byte, 8 means used up
  logic [4:0] bit_cnt, next_bit_cnt;     // bits gathered for a symbol or the count
  logic [1:0] wait_cnt, next_wait_cnt;   // cycles spent in fetch
  sym_t       sym_q, next_sym;           // symbol of the current leaf
  tot_count_t tot_q, next_tot;           // total count being shifted in
  logic       byte_empty;
  logic       cur_bit;

  assign byte_empty = bit_ptr[3];                    // all 8 bits consumed
  assign cur_bit    = spi_byte[3'd7 - bit_ptr[2:0]]; // msb of the byte comes first

  assign cb_wr_sym   = sym_q;
  assign cb_wr_path  = path;
  assign tot_chars   = tot_q;
  assign hd_finished = (state == HD_DONE); // level, sticky until reset

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state     <= HD_IDLE;
      ret_state <= HD_READ_NODE;
      path      <= ROOT_PATH;
      bit_ptr   <= 4'd8;  // nothing buffered until the first fetch
      bit_cnt   <= '0;
      wait_cnt  <= '0;
      tot_q     <= '0;
    end else begin
      state     <= next_state;
      ret_state <= next_ret_state;
      path      <= next_path;
      bit_ptr   <= next_bit_ptr;
      bit_cnt   <= next_bit_cnt;
      wait_cnt  <= next_wait_cnt;
      tot_q     <= next_tot;
    end
  end

  always_ff @(posedge clk) begin
    sym_q <= next_sym; // only read after all 8 bits are shifted in
  end

  always_comb begin
    next_state     = state;
    next_ret_state = ret_state;
    next_path      = path;
    next_bit_ptr   = bit_ptr;
    next_bit_cnt   = bit_cnt;
    next_wait_cnt  = wait_cnt;
    next_sym       = sym_q;
    next_tot       = tot_q;
    byte_req       = 1'b0;
    cb_wr_en       = 1'b0;

    case (state)
      HD_IDLE: begin
        if (hd_enable) begin
          next_state     = HD_FETCH;     // first byte of the header
          next_ret_state = HD_READ_NODE; // the header opens with the root node
          next_path      = ROOT_PATH;
        end
      end

      HD_FETCH: begin
        byte_req = (wait_cnt == 2'd0); // single cycle strobe on entry
        if (wait_cnt == 2'd2) begin
          // two cycles have passed since the request so spi_byte is stable
          next_wait_cnt = '0;
          next_bit_ptr  = '0;
          next_state    = ret_state;
        end else begin
          next_wait_cnt = wait_cnt + 2'd1;
        end
      end

      HD_READ_NODE: begin
        if (byte_empty) begin
          next_state     = HD_FETCH;
          next_ret_state = HD_READ_NODE;
        end else begin
          next_bit_ptr = bit_ptr + 4'd1;
          if (cur_bit) begin
            next_bit_cnt = '0;          // leaf, its symbol follows
            next_state   = HD_READ_SYM;
          end else begin
            next_path = {path[126:0], 1'b0}; // internal node, go left first
          end
        end
      end

      HD_READ_SYM: begin
        if (byte_empty) begin
          next_state     = HD_FETCH;
          next_ret_state = HD_READ_SYM;
        end else begin
          next_bit_ptr = bit_ptr + 4'd1;
          next_sym     = {sym_q[6:0], cur_bit}; // symbol bits arrive msb first
          next_bit_cnt = bit_cnt + 5'd1;
          if (bit_cnt == 5'd7) begin
            next_state = HD_WRITE_PATH;
          end
        end
      end

      HD_WRITE_PATH: begin
        cb_wr_en   = 1'b1; // exactly one write per leaf
        next_state = HD_BACKTRACK;
      end

      HD_BACKTRACK: begin
        if (path == ROOT_PATH) begin
          // every right branch has been taken, so the tree is complete
          next_bit_cnt = '0;
          next_state   = HD_READ_TOTAL;
        end else if (path[0]) begin
          next_path = {1'b0, path[127:1]}; // drop a right move and climb up
        end else begin
          next_path  = {path[127:1], 1'b1}; // last left becomes its right sibling
          next_state = HD_READ_NODE;
        end
      end

      HD_READ_TOTAL: begin
        // the count follows the last tree bit directly in the bitstream
        if (byte_empty) begin
          next_state     = HD_FETCH;
          next_ret_state = HD_READ_TOTAL;
        end else begin
          next_bit_ptr = bit_ptr + 4'd1;
          next_tot     = {tot_q[30:0], cur_bit}; // msb first
          next_bit_cnt = bit_cnt + 5'd1;
          if (bit_cnt == 5'd31) begin
            next_state = HD_DONE;
          end
        end
      end

      HD_DONE: begin
        next_state = HD_DONE; // only reset leaves here
      end

      default: begin
        next_state = HD_IDLE;
      end
    endcase
  end

endmodule

/* logic/codebook_ram.sv */
// huffman codebook storage
// one code path per symbol value with a registered read port, plus a
// valid flag per entry so symbols missing from the tree read as invalid

`timescale 1ns/1ps

module codebook_ram #(
  parameter int SYM_COUNT = hd_pkg::SYM_COUNT
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               wr_en,
  input  hd_pkg::sym_t       wr_sym,
  input  hd_pkg::code_path_t wr_path,
  input  hd_pkg::sym_t       rd_sym,
  output hd_pkg::code_path_t rd_path,
  output logic               rd_valid
);
  import hd_pkg::*;

  code_path_t           mem [SYM_COUNT]; // path storage, contents undefined until written
  logic [SYM_COUNT-1:0] valid;           // set once the decoder writes that symbol

  // path array, written by the decoder and read one cycle late by the serializer
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_sym] <= wr_path;
    end
    rd_path <= mem[rd_sym]; // a same-cycle write returns the old path
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid    <= '0; // a new header starts from an empty codebook
      rd_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        valid[wr_sym] <= 1'b1;
      end
      rd_valid <= valid[rd_sym]; // lines up with rd_path
    end
  end

endmodule

/* logic/code_serializer.sv */
// huffman code serializer
// looks up a requested symbol in the codebook and shifts its code out
// one bit per cycle, counting encoded symbols against the file total

`timescale 1ns/1ps

module code_serializer (
  input  logic               clk,
  input  logic               rst,
  input  logic               hd_finished,
  input  hd_pkg::tot_count_t tot_chars,
  input  logic               sym_req,
  input  hd_pkg::sym_t       sym_in,
  output hd_pkg::sym_t       cb_rd_sym,
  input  hd_pkg::code_path_t cb_rd_path,
  input  logic               cb_rd_valid,
  output logic               code_bit,
  output logic               bit_valid,
  output logic               bit_last,
  output logic               sym_miss,
  output logic               file_done
);
  import hd_pkg::*;

  ser_state_t state, next_state;
  sym_t       sym_q;    // latched read address
  code_path_t path_q;   // path held for the bits after the first
  path_len_t  idx_q;    // bit of path_q that goes out next
  logic       first_q;  // first shift cycle, path still on the ram output
  tot_count_t enc_cnt;  // symbols fully encoded so far
  path_len_t  code_len; // sentinel position equals the number of moves
  code_path_t cur_path;
  path_len_t  cur_idx;
  logic       accept;

  assign accept    = sym_req && hd_finished && (state == SER_IDLE); // busy requests drop
  assign cb_rd_sym = sym_q;

  // the highest set bit is the sentinel
  always_comb begin
    code_len = '0;
    for (int i = 1; i < $bits(code_path_t); i++) begin
      if (cb_rd_path[i]) begin
        code_len = path_len_t'(i);
      end
    end
  end

  assign cur_path = first_q ? cb_rd_path : path_q;
  assign cur_idx  = first_q ? code_len - path_len_t'(1) : idx_q; // just below the sentinel

  assign bit_valid = (state == SER_SHIFT) && (!first_q || cb_rd_valid);
  assign sym_miss  = (state == SER_SHIFT) && first_q && !cb_rd_valid; // no bits follow
  assign code_bit  = bit_valid && cur_path[cur_idx];
  assign bit_last  = bit_valid && (cur_idx == '0); // bit 0 holds the final move

  always_comb begin
    next_state = state;
    case (state)
      SER_IDLE:   if (accept) next_state = SER_LOOKUP;
      SER_LOOKUP: next_state = SER_SHIFT; // ram read registers during this cycle
      SER_SHIFT:  if (sym_miss || bit_last) next_state = SER_IDLE;
      default:    next_state = SER_IDLE;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state     <= SER_IDLE;
      first_q   <= 1'b0;
      enc_cnt   <= '0;
      file_done <= 1'b0;
    end else begin
      state   <= next_state;
      first_q <= (state == SER_LOOKUP); // high for the first shift cycle only
      if (bit_last) begin
        enc_cnt <= enc_cnt + tot_count_t'(1);
        if (enc_cnt + tot_count_t'(1) == tot_chars) begin
          file_done <= 1'b1; // level, stays up until reset
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sym_q <= sym_in;
    end
    if (state == SER_SHIFT) begin
      path_q <= cur_path;                   // keeps the path once the ram moves on
      idx_q  <= cur_idx - path_len_t'(1);   // walk down toward bit 0
    end
  end

endmodule

/* logic/huffman_codebook_top.sv */
// huffman codebook subsystem top
// the header decoder fills the codebook from spi header bytes and the
// serializer reads it back to emit code bits for requested symbols

`timescale 1ns/1ps

module huffman_codebook_top #(
  parameter int SYM_COUNT = hd_pkg::SYM_COUNT
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         hd_enable,
  input  hd_pkg::sym_t spi_byte,
  output logic         byte_req,
  input  logic         sym_req,
  input  hd_pkg::sym_t sym_in,
  output logic         code_bit,
  output logic         bit_valid,
  output logic         bit_last,
  output logic         sym_miss,
  output logic         file_done,
  output logic         hd_finished
);
  import hd_pkg::*;

  logic       cb_wr_en;    // one pulse per leaf from the decoder
  sym_t       cb_wr_sym;
  code_path_t cb_wr_path;
  sym_t       cb_rd_sym;   // serializer read address
  code_path_t cb_rd_path;  // registered read data
  logic       cb_rd_valid;
  tot_count_t tot_chars;   // file length from the header

  header_decoder u_decoder (
    .clk         (clk),
    .rst         (rst),
    .hd_enable   (hd_enable),
    .spi_byte    (spi_byte),
    .byte_req    (byte_req),
    .cb_wr_en    (cb_wr_en),
    .cb_wr_sym   (cb_wr_sym),
    .cb_wr_path  (cb_wr_path),
    .tot_chars   (tot_chars),
    .hd_finished (hd_finished)
  );

  codebook_ram #(
    .SYM_COUNT (SYM_COUNT)
  ) u_codebook (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (cb_wr_en),
    .wr_sym   (cb_wr_sym),
    .wr_path  (cb_wr_path),
    .rd_sym   (cb_rd_sym),
    .rd_path  (cb_rd_path),
    .rd_valid (cb_rd_valid)
  );

  code_serializer u_serializer (
    .clk         (clk),
    .rst         (rst),
    .hd_finished (hd_finished),
    .tot_chars   (tot_chars),
    .sym_req     (sym_req),
    .sym_in      (sym_in),
    .cb_rd_sym   (cb_rd_sym),
    .cb_rd_path  (cb_rd_path),
    .cb_rd_valid (cb_rd_valid),
    .code_bit    (code_bit),
    .bit_valid   (bit_valid),
    .bit_last    (bit_last),
    .sym_miss    (sym_miss),
    .file_done   (file_done)
  );

endmodule

/* dv/huffman_codebook_checker.sv */
// huffman codebook protocol checker
// concurrent assertions on request and strobe legality, bound into the top

`timescale 1ns/1ps

module huffman_codebook_checker (
  input logic               clk,
  input logic               rst,
  input logic               sym_req,
  input hd_pkg::ser_state_t ser_state,
  input logic               bit_valid,
  input logic               bit_last,
  input logic               cb_wr_en,
  input logic               hd_finished
);
  import hd_pkg::*;

  int fail_cnt = 0; // number of assertion failures seen so far

  req_while_idle: assert property (@(posedge clk) disable iff (rst)
    sym_req |-> (ser_state == SER_IDLE))
    else begin
      fail_cnt++;
      $error("sym_req arrived while the serializer was busy");
    end

  // the last bit rides on a valid bit and the serializer then drops back to idle
  last_needs_valid: assert property (@(posedge clk) disable iff (rst)
    bit_last |-> bit_valid ##1 !bit_valid)
    else begin
      fail_cnt++;
      $error("bit_last without bit_valid, or a bit right after bit_last");
    end

  no_write_after_done: assert property (@(posedge clk) disable iff (rst)
    hd_finished |-> !cb_wr_en)
    else begin
      fail_cnt++;
      $error("codebook write after hd_finished");
    end

endmodule

bind huffman_codebook_top huffman_codebook_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .sym_req     (sym_req),
  .ser_state   (u_serializer.state),
  .bit_valid   (bit_valid),
  .bit_last    (bit_last),
  .cb_wr_en    (cb_wr_en),
  .hd_finished (hd_finished)
);

/* dv/huffman_codebook_tb.sv */
// huffman codebook testbench
// builds trees, serializes them into header bytes served by an spi byte
// model, and checks every code the serializer emits against the tree walk

`timescale 1ns/1ps

module huffman_codebook_tb;
  import hd_pkg::*;

  localparam int BALANCED = 0; // tree shapes for the builder
  localparam int CHAIN    = 1;
  localparam int RANDOM   = 2;

  logic       clk;
  logic       rst;
  logic       hd_enable;
  logic       sym_req;
  sym_t       sym_in;
  sym_t       spi_byte;
  logic       byte_req;
  logic       code_bit;
  logic       bit_valid;
  logic       bit_last;
  logic       sym_miss;
  logic       file_done;
  logic       hd_finished;
  bit         hdr_bits[$];         // tree bits then count bits, in stream order
  sym_t       hdr_bytes[$];        // what the spi model hands out
  sym_t       tree_syms[$];        // leaves in preorder
  bit         in_tree[SYM_COUNT];
  int         exp_len[SYM_COUNT];
  bit [127:0] exp_moves[SYM_COUNT]; // move i of the code sits at index i
  int         leaf_idx;
  sym_t       sym_base;
  sym_t       sym_step;            // odd, so leaf symbols never repeat
  int         spi_idx;
  longint     budget;              // cycles the watchdog allows so far
  longint     cycles;

  huffman_codebook_top #(.SYM_COUNT(SYM_COUNT)) u_dut (
    .clk(clk), .rst(rst), .hd_enable(hd_enable), .spi_byte(spi_byte),
    .byte_req(byte_req), .sym_req(sym_req), .sym_in(sym_in),
    .code_bit(code_bit), .bit_valid(bit_valid), .bit_last(bit_last),
    .sym_miss(sym_miss), .file_done(file_done), .hd_finished(hd_finished)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // spi byte source, the byte is out one edge after byte_req is seen
  always @(posedge clk) begin
    if (rst) begin
      spi_idx <= 0;
    end else if (byte_req) begin
      spi_byte <= (spi_idx < hdr_bytes.size()) ? hdr_bytes[spi_idx] : 8'h00;
      spi_idx  <= spi_idx + 1;
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > budget)
        abort_run($sformatf("timeout: the run did not finish within %0d cycles", budget));
      if (u_dut.u_checker.fail_cnt != 0)
        abort_run("a protocol assertion in the checker failed");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_sym_miss(input logic got, input logic exp, input sym_t s);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: sym_miss for %h is %b, expected %b", $time, s, got, exp));
  endtask

  task automatic check_count(input tot_count_t got, input tot_count_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // preorder emit, 0 for an internal node and 1 plus 8 symbol bits for a leaf
  task automatic emit_subtree(input int n, input int shape, input int depth,
                              input bit [127:0] moves);
    int         k;
    sym_t       s;
    bit [127:0] left_moves;
    bit [127:0] right_moves;
    if (n == 1) begin
      s = sym_base + sym_t'(leaf_idx) * sym_step;
      leaf_idx++;
      hdr_bits.push_back(1'b1);
      for (int b = 7; b >= 0; b--) hdr_bits.push_back(s[b]);
      in_tree[s]   = 1'b1;
      exp_len[s]   = depth; // one move per level below the root
      exp_moves[s] = moves;
      tree_syms.push_back(s);
    end else begin
      hdr_bits.push_back(1'b0);
      if (shape == BALANCED) k = n / 2;
      else if (shape == CHAIN) k = 1; // leaf on the left, the rest hangs right
      else k = 1 + int'($urandom % (n - 1));
      left_moves         = moves;
      right_moves        = moves;
      right_moves[depth] = 1'b1;
      emit_subtree(k, shape, depth + 1, left_moves);
      emit_subtree(n - k, shape, depth + 1, right_moves);
    end
  endtask

  task automatic reset_dut();
    budget += 20;
    @(posedge clk);
    rst       <= 1'b1;
    hd_enable <= 1'b0;
    sym_req   <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit(hd_finished, 1'b0, "hd_finished after reset");
    check_bit(file_done, 1'b0, "file_done after reset");
  endtask

  // builds the header, lets the decoder parse it and checks the captured count
  task automatic load_tree(input int n, input int shape, input sym_t base, input sym_t step,
                           input tot_count_t tot);
    sym_t byte_v;
    hdr_bits.delete();
    hdr_bytes.delete();
    tree_syms.delete();
    foreach (in_tree[i]) in_tree[i] = 1'b0;
    leaf_idx = 0;
    sym_base = base;
    sym_step = step;
    emit_subtree(n, shape, 0, '0);
    for (int b = 31; b >= 0; b--) hdr_bits.push_back(tot[b]);
    while (hdr_bits.size() % 8 != 0) hdr_bits.push_back(1'b0); // pad the last byte
    for (int i = 0; i < hdr_bits.size(); i += 8) begin
      for (int b = 0; b < 8; b++) byte_v[7 - b] = hdr_bits[i + b];
      hdr_bytes.push_back(byte_v);
    end
    budget += 200 * hdr_bytes.size();
    @(posedge clk);
    hd_enable <= 1'b1;
    while (hd_finished !== 1'b1) @(negedge clk);
    check_count(u_dut.tot_chars, tot, "tot_chars");
    check_count(tot_count_t'(spi_idx), tot_count_t'(hdr_bytes.size()), "header bytes requested");
  endtask

  // one request, first response exactly two cycles after the drive edge
  task automatic encode_sym(input sym_t s);
    int len;
    len = in_tree[s] ? exp_len[s] : 1;
    budget += 150 * len;
    @(posedge clk);
    sym_req <= 1'b1;
    sym_in  <= s;
    @(posedge clk);
    sym_req <= 1'b0;
    @(negedge clk);
    check_bit(bit_valid, 1'b0, "bit_valid during lookup");
    @(negedge clk);
    if (!in_tree[s]) begin
      check_sym_miss(sym_miss, 1'b1, s);
      check_bit(bit_valid, 1'b0, $sformatf("bit_valid for absent %h", s));
      @(negedge clk);
      check_sym_miss(sym_miss, 1'b0, s);
      check_bit(bit_valid, 1'b0, $sformatf("bit_valid after miss of %h", s));
    end else begin
      check_sym_miss(sym_miss, 1'b0, s);
      for (int i = 0; i < len; i++) begin
        if (i > 0) @(negedge clk);
        check_bit(bit_valid, 1'b1, $sformatf("bit_valid of %h bit %0d", s, i));
        check_bit(code_bit, exp_moves[s][i], $sformatf("code_bit of %h bit %0d", s, i));
        check_bit(bit_last, i == len - 1, $sformatf("bit_last of %h bit %0d", s, i));
      end
    end
  endtask

  task automatic test_balanced();
    reset_dut();
    load_tree(4, BALANCED, 8'h41, 8'h01, 32'h0001_2345);
    foreach (tree_syms[i]) encode_sym(tree_syms[i]);
  endtask

  task automatic test_chain();
    reset_dut();
    load_tree(21, CHAIN, 8'h80, 8'h03, 32'h00c0_ffee); // deepest leaves sit at 20
    foreach (tree_syms[i]) encode_sym(tree_syms[i]);
  endtask

  task automatic test_random();
    int n;
    n = 2 + int'($urandom % 39);
    reset_dut();
    load_tree(n, RANDOM, sym_t'($urandom), sym_t'($urandom) | 8'h01, tot_count_t'($urandom));
    foreach (tree_syms[i]) encode_sym(tree_syms[i]);
  endtask

  task automatic test_miss();
    reset_dut();
    load_tree(4, BALANCED, 8'h41, 8'h01, 32'd100);
    encode_sym(8'h00);
    encode_sym(8'h99);
    encode_sym(8'hff);
    encode_sym(8'h42); // a hit right after misses
  endtask

  task automatic test_done_and_reset();
    reset_dut();
    load_tree(4, BALANCED, 8'h41, 8'h01, 32'd6);
    check_bit(file_done, 1'b0, "file_done before any symbol");
    for (int j = 0; j < 6; j++) begin
      if (j == 2) encode_sym(8'h99); // misses do not count
      encode_sym(tree_syms[j % 4]);
      @(negedge clk);
      check_bit(file_done, j == 5, $sformatf("file_done after %0d symbols", j + 1));
    end
    reset_dut();
    load_tree(4, BALANCED, 8'h10, 8'h01, 32'd1000);
    for (int s = 0; s < SYM_COUNT; s++) encode_sym(sym_t'(s)); // old leaves must miss
  endtask

  initial begin
    void'($urandom(65));
    budget    = 0;
    rst       = 1'b1;
    hd_enable = 1'b0;
    sym_req   = 1'b0;
    sym_in    = '0;
    spi_byte  = '0;
    test_balanced();
    test_chain();
    test_random();
    test_miss();
    test_done_and_reset();
    if (u_dut.u_checker.fail_cnt != 0) begin
      abort_run("a protocol assertion in the checker failed");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* sources.f */
logic/hd_pkg.sv
logic/header_decoder.sv
logic/codebook_ram.sv
logic/code_serializer.sv
logic/huffman_codebook_top.sv
dv/huffman_codebook_checker.sv
dv/huffman_codebook_tb.sv
